// ==== pr_region.f ====
logic/pr_pkg.sv
logic/pipe_reg.sv
logic/pkt_mem.sv
logic/desc_router.sv
logic/core_status.sv
logic/pr_region.sv
testbench/pr_region_assert.sv
testbench/pr_region_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := pr_region_tb
FILELIST  := pr_region.f
OBJ_DIR   := obj_dir

SRCS := $(shell grep -E '\.s?v$$' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/pr_region_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pr_region_tb;

  import pr_pkg::*;

  localparam int NSTEPS    = 18;
  localparam int MEM_BYTES = 65536;
  localparam int K_WR = 0, K_RD = 1, K_DESC = 2, K_BCIN = 3, K_MAP = 4, K_CRST = 5, K_STAT = 6;
  // Full strobes and ready, random, or ready held low for a while
  localparam int M_FULL = 0, M_RAND = 1, M_HOLD = 2;

  typedef struct {
    int                    kind;
    logic [ADDR_WIDTH-1:0] addr;
    int                    mode;
    int                    count;
  } step_t;

  logic                  clk = 1'b0;
  logic                  rst, core_reset;
  logic                  dma_cmd_wr_en, dma_cmd_wr_ready;
  logic [ADDR_WIDTH-1:0] dma_cmd_wr_addr, dma_cmd_rd_addr;
  line_t                 dma_cmd_wr_data, dma_rd_resp_data;
  logic [STRB_WIDTH-1:0] dma_cmd_wr_strb;
  logic                  dma_cmd_rd_en, dma_cmd_rd_ready;
  logic                  dma_rd_resp_valid, dma_rd_resp_ready;
  desc_t                 in_desc, out_desc;
  logic                  in_desc_valid, in_desc_taken;
  logic                  out_desc_2nd, out_desc_valid, out_desc_ready;
  bc_msg_t               bc_msg_in, bc_msg_out;
  logic                  bc_msg_in_valid, bc_msg_out_valid, bc_msg_out_ready;
  logic [31:0]           wrapper_status_data, core_status_data;
  logic [2:0]            wrapper_status_addr;
  logic [1:0]            core_status_addr;

  step_t       steps [NSTEPS];
  int          nsteps_built = 0;
  logic [31:0] seed = 32'h598f;
  line_t       mem_model [int];
  logic [3:0]  map_model [8];
  bit          map_on = 0;
  int          desc_total = 0;
  int          bc_count_m = 0;
  logic [31:0] bc_last_m = '0;
  line_t       exp_lines [$];
  desc_t       exp_descs [$];
  bit          exp_2nd [$];
  bc_msg_t     exp_msgs [$];

  pr_region dut (.*);

  always #2 clk = ~clk;

  initial begin
    repeat (NSTEPS * 64 + 200) @(posedge clk);
    $display("Watchdog expired, the test did not finish in time");
    $display("Result: FAILED");
    $fatal(1, "watchdog");
  end

  function logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function bit ready_for(int mode, int cyc);
    logic [31:0] r;
    r = next_rand();
    if (mode == M_FULL) return 1'b1;
    if (mode == M_HOLD && cyc < 24) return 1'b0;
    return r[0];
  endfunction

  task automatic fail_stop(string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "check failed");
  endtask

  //////////////////////////////
  // Compare tasks
  task automatic check_line(line_t got, line_t exp);
    if (got !== exp)
      fail_stop($sformatf("Mismatch at %0t: dma_rd_resp_data got %h expected %h",
                          $time, got, exp));
  endtask

  task automatic check_desc(desc_t got, logic got_2nd, desc_t exp, logic exp_2nd);
    if (got !== exp)
      fail_stop($sformatf("Mismatch at %0t: out_desc got %h expected %h", $time, got, exp));
    if (got_2nd !== exp_2nd)
      fail_stop($sformatf("Mismatch at %0t: out_desc_2nd got %b expected %b",
                          $time, got_2nd, exp_2nd));
  endtask

  task automatic check_msg(bc_msg_t got, bc_msg_t exp);
    if (got !== exp)
      fail_stop($sformatf("Mismatch at %0t: bc_msg_out got %h expected %h", $time, got, exp));
  endtask

  task automatic check_status(logic [1:0] addr, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
      fail_stop($sformatf("Mismatch at %0t: core_status_data[%0d] got %h expected %h",
                          $time, addr, got, exp));
  endtask

  //////////////////////////////
  // Step tasks
  task automatic write_lines(logic [ADDR_WIDTH-1:0] addr, int mode, int count);
    logic [ADDR_WIDTH-1:0] a;
    logic [31:0]           r;
    line_t                 d;
    logic [15:0]           s;
    bc_msg_t               m;
    logic [1:0]            lane;
    int                    line;
    bit                    in_bc;
    bit                    saw_stall;
    int                    cyc;
    int                    got;
    in_bc = addr >= BC_START_ADDR && addr < PMEM_BASE + ADDR_WIDTH'(MEM_BYTES);
    saw_stall = 0;
    fork
      begin
        for (int i = 0; i < count; i++) begin
          @(negedge clk);
          a = addr + ADDR_WIDTH'(i * (in_bc ? 20 : 16));
          d = {next_rand(), next_rand(), next_rand(), next_rand()};
          r = next_rand();
          s = (mode == M_FULL) ? 16'hFFFF : r[15:0];
          dma_cmd_wr_en = 1'b1;
          dma_cmd_wr_addr = a;
          dma_cmd_wr_data = d;
          dma_cmd_wr_strb = s;
          line = int'((a - PMEM_BASE) >> 4);
          if (!mem_model.exists(line)) mem_model[line] = 'x;
          for (int b = 0; b < STRB_WIDTH; b++) begin
            if (s[b]) mem_model[line][b*8 +: 8] = d[b*8 +: 8];
          end
          if (in_bc) begin
            lane = a[3:2];
            m.data = d[lane*32 +: 32];
            m.strb = s[lane*4 +: 4];
            m.idx = BC_IDX_WIDTH'((a - BC_START_ADDR) >> 2);
            exp_msgs.push_back(m);
          end
          while (!dma_cmd_wr_ready) begin
            saw_stall = 1;
            @(negedge clk);
          end
        end
        @(negedge clk);
        dma_cmd_wr_en = 1'b0;
      end
      begin
        cyc = 0;
        got = 0;
        while (got < (in_bc ? count : 0)) begin
          @(negedge clk);
          bc_msg_out_ready = ready_for(mode, cyc);
          cyc++;
          if (bc_msg_out_valid && bc_msg_out_ready) begin
            check_msg(bc_msg_out, exp_msgs.pop_front());
            got++;
          end
        end
      end
    join
    @(negedge clk);
    bc_msg_out_ready = 1'b1;
    if (mode == M_HOLD && !saw_stall)
      fail_stop("Write ready never dropped while the broadcast output was held");
  endtask

  task automatic read_lines(logic [ADDR_WIDTH-1:0] addr, int mode, int count);
    logic [ADDR_WIDTH-1:0] a;
    int                    cyc;
    int                    got;
    fork
      begin
        for (int i = 0; i < count; i++) begin
          @(negedge clk);
          a = addr + ADDR_WIDTH'(i * 16);
          dma_cmd_rd_en = 1'b1;
          dma_cmd_rd_addr = a;
          if (a >= PMEM_BASE && a < PMEM_BASE + ADDR_WIDTH'(MEM_BYTES))
            exp_lines.push_back(mem_model[int'((a - PMEM_BASE) >> 4)]);
          else
            exp_lines.push_back('0);
          while (!dma_cmd_rd_ready) @(negedge clk);
        end
        @(negedge clk);
        dma_cmd_rd_en = 1'b0;
      end
      begin
        cyc = 0;
        got = 0;
        while (got < count) begin
          @(negedge clk);
          dma_rd_resp_ready = ready_for(mode, cyc);
          cyc++;
          if (dma_rd_resp_valid && dma_rd_resp_ready) begin
            check_line(dma_rd_resp_data, exp_lines.pop_front());
            got++;
          end
        end
      end
    join
    @(negedge clk);
    dma_rd_resp_ready = 1'b1;
  endtask

  task automatic route_descs(int mode, int count);
    desc_t      d;
    desc_t      e;
    logic [3:0] entry;
    int         cyc;
    int         got;
    fork
      begin
        for (int i = 0; i < count; i++) begin
          @(negedge clk);
          d = desc_t'({next_rand(), next_rand()});
          // Step through every map entry
          d.port[2:0] = 3'(i);
          e = d;
          entry = map_model[d.port[2:0]];
          if (map_on && entry != 4'hF) e.port = entry;
          exp_descs.push_back(e);
          exp_2nd.push_back(map_on && entry == 4'hF);
          in_desc = d;
          in_desc_valid = 1'b1;
          desc_total++;
          while (!in_desc_taken) @(negedge clk);
        end
        @(negedge clk);
        in_desc_valid = 1'b0;
      end
      begin
        cyc = 0;
        got = 0;
        while (got < count) begin
          @(negedge clk);
          out_desc_ready = ready_for(mode, cyc);
          cyc++;
          if (out_desc_valid && out_desc_ready) begin
            check_desc(out_desc, out_desc_2nd, exp_descs.pop_front(), exp_2nd.pop_front());
            got++;
          end
        end
      end
    join
    @(negedge clk);
    out_desc_ready = 1'b1;
  endtask

  task automatic send_bc_in(int count);
    logic [31:0] r1;
    logic [31:0] r2;
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      r1 = next_rand();
      r2 = next_rand();
      bc_msg_in = bc_msg_t'({r1, r2[14:0]});
      bc_msg_in_valid = 1'b1;
      bc_count_m++;
      bc_last_m = r1;
    end
    @(negedge clk);
    bc_msg_in_valid = 1'b0;
  endtask

  task automatic load_map();
    logic [31:0] r;
    r = next_rand();
    // Two entries release the slot
    r[11:8] = 4'hF;
    r[23:20] = 4'hF;
    @(negedge clk);
    wrapper_status_data = r;
    wrapper_status_addr = STAT_PORT_MAP;
    for (int i = 0; i < 8; i++) map_model[i] = r[i*4 +: 4];
    map_on = 1;
    @(negedge clk);
    wrapper_status_addr = 3'd0;
    repeat (4) @(negedge clk);
  endtask

  task automatic pulse_core_reset();
    @(negedge clk);
    core_reset = 1'b1;
    repeat (2) @(negedge clk);
    core_reset = 1'b0;
    repeat (4) @(negedge clk);
    desc_total = 0;
    bc_count_m = 0;
    bc_last_m = '0;
    map_on = 0;
  endtask

  task automatic verify_status();
    logic [31:0] exp;
    repeat (6) @(negedge clk);
    for (int a = 0; a < 4; a++) begin
      case (a)
        0, 1: exp = 32'(desc_total);
        2: exp = 32'(bc_count_m);
        default: exp = bc_last_m;
      endcase
      @(negedge clk);
      while (core_status_addr != 2'(a)) @(negedge clk);
      check_status(2'(a), core_status_data, exp);
    end
  endtask

  task automatic add_step(int kind, logic [ADDR_WIDTH-1:0] addr, int mode, int count);
    steps[nsteps_built] = '{kind, addr, mode, count};
    nsteps_built++;
  endtask

  //////////////////////////////
  // Main sequence
  initial begin
    rst = 1'b1;
    core_reset = 1'b0;
    dma_cmd_wr_en = 1'b0;
    dma_cmd_wr_addr = '0;
    dma_cmd_wr_data = '0;
    dma_cmd_wr_strb = '0;
    dma_cmd_rd_en = 1'b0;
    dma_cmd_rd_addr = '0;
    dma_rd_resp_ready = 1'b1;
    in_desc = '0;
    in_desc_valid = 1'b0;
    out_desc_ready = 1'b1;
    bc_msg_in = '0;
    bc_msg_in_valid = 1'b0;
    bc_msg_out_ready = 1'b1;
    wrapper_status_data = '0;
    wrapper_status_addr = 3'd0;

    add_step(K_WR, PMEM_BASE, M_FULL, 8);
    add_step(K_WR, PMEM_BASE, M_RAND, 8);
    add_step(K_RD, PMEM_BASE, M_FULL, 8);
    add_step(K_RD, PMEM_BASE - 26'h40, M_RAND, 4);
    add_step(K_RD, PMEM_BASE + 26'h10000, M_FULL, 2);
    add_step(K_WR, BC_START_ADDR + 26'h4, M_HOLD, 8);
    add_step(K_WR, BC_START_ADDR + 26'h100, M_RAND, 6);
    add_step(K_RD, PMEM_BASE, M_RAND, 8);
    add_step(K_DESC, '0, M_FULL, 6);
    add_step(K_MAP, '0, M_FULL, 0);
    add_step(K_DESC, '0, M_RAND, 8);
    add_step(K_BCIN, '0, M_FULL, 5);
    add_step(K_STAT, '0, M_FULL, 0);
    add_step(K_CRST, '0, M_FULL, 0);
    add_step(K_STAT, '0, M_FULL, 0);
    add_step(K_DESC, '0, M_RAND, 6);
    add_step(K_RD, PMEM_BASE, M_FULL, 4);
    add_step(K_STAT, '0, M_FULL, 0);

    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);

    for (int i = 0; i < NSTEPS; i++) begin
      case (steps[i].kind)
        K_WR:    write_lines(steps[i].addr, steps[i].mode, steps[i].count);
        K_RD:    read_lines(steps[i].addr, steps[i].mode, steps[i].count);
        K_DESC:  route_descs(steps[i].mode, steps[i].count);
        K_BCIN:  send_bc_in(steps[i].count);
        K_MAP:   load_map();
        K_CRST:  pulse_core_reset();
        default: verify_status();
      endcase
    end

    repeat (4) @(negedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/pr_region_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module pr_region_assert (
  input logic                          clk,
  input logic                          rst_r,
  input logic                          desc_rst,
  input logic                          dma_rd_resp_valid,
  input logic                          dma_rd_resp_ready,
  input logic [pr_pkg::DATA_WIDTH-1:0] dma_rd_resp_data,
  input logic                          out_desc_valid,
  input logic                          out_desc_ready,
  input logic [pr_pkg::DESC_WIDTH-1:0] out_desc,
  input logic                          out_desc_2nd,
  input logic                          bc_msg_out_valid,
  input logic                          bc_msg_out_ready,
  input logic [pr_pkg::MSG_WIDTH-1:0]  bc_msg_out
);

  //////////////////////////////
  // Valid holds until taken
  resp_hold: assert property (@(posedge clk) disable iff (rst_r)
    dma_rd_resp_valid && !dma_rd_resp_ready |=> dma_rd_resp_valid && $stable(dma_rd_resp_data))
    else $error("read response dropped or changed while stalled");

  desc_hold: assert property (@(posedge clk) disable iff (desc_rst)
    out_desc_valid && !out_desc_ready |=>
      out_desc_valid && $stable(out_desc) && $stable(out_desc_2nd))
    else $error("output descriptor dropped or changed while stalled");

  msg_hold: assert property (@(posedge clk) disable iff (rst_r)
    bc_msg_out_valid && !bc_msg_out_ready |=> bc_msg_out_valid && $stable(bc_msg_out))
    else $error("broadcast message dropped or changed while stalled");

  // Nothing valid right after reset
  reset_quiet: assert property (@(posedge clk)
    rst_r |=> !dma_rd_resp_valid && !out_desc_valid && !bc_msg_out_valid)
    else $error("valid output high after reset");

endmodule

bind pr_region pr_region_assert assert_inst (
  .clk(clk), .rst_r(rst_r), .desc_rst(desc_rst),
  .dma_rd_resp_valid(dma_rd_resp_valid), .dma_rd_resp_ready(dma_rd_resp_ready),
  .dma_rd_resp_data(dma_rd_resp_data),
  .out_desc_valid(out_desc_valid), .out_desc_ready(out_desc_ready),
  .out_desc(out_desc), .out_desc_2nd(out_desc_2nd),
  .bc_msg_out_valid(bc_msg_out_valid), .bc_msg_out_ready(bc_msg_out_ready),
  .bc_msg_out(bc_msg_out)
);

`default_nettype wire

// ==== logic/pr_region.sv ====
`timescale 1ns/1ps
`default_nettype none

module pr_region (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          core_reset,

  // DMA
  input  logic                          dma_cmd_wr_en,
  input  logic [pr_pkg::ADDR_WIDTH-1:0] dma_cmd_wr_addr,
  input  logic [pr_pkg::DATA_WIDTH-1:0] dma_cmd_wr_data,
  input  logic [pr_pkg::STRB_WIDTH-1:0] dma_cmd_wr_strb,
  output logic                          dma_cmd_wr_ready,

  input  logic                          dma_cmd_rd_en,
  input  logic [pr_pkg::ADDR_WIDTH-1:0] dma_cmd_rd_addr,
  output logic                          dma_cmd_rd_ready,

  output logic                          dma_rd_resp_valid,
  output logic [pr_pkg::DATA_WIDTH-1:0] dma_rd_resp_data,
  input  logic                          dma_rd_resp_ready,

  // Descriptors
  input  logic [pr_pkg::DESC_WIDTH-1:0] in_desc,
  input  logic                          in_desc_valid,
  output logic                          in_desc_taken,

  output logic [pr_pkg::DESC_WIDTH-1:0] out_desc,
  output logic                          out_desc_2nd,
  output logic                          out_desc_valid,
  input  logic                          out_desc_ready,

  // Broadcast messages
  input  logic [pr_pkg::MSG_WIDTH-1:0]  bc_msg_in,
  input  logic                          bc_msg_in_valid,
  output logic [pr_pkg::MSG_WIDTH-1:0]  bc_msg_out,
  output logic                          bc_msg_out_valid,
  input  logic                          bc_msg_out_ready,

  // Status channels
  input  logic [31:0]                   wrapper_status_data,
  input  logic [2:0]                    wrapper_status_addr,
  output logic [31:0]                   core_status_data,
  output logic [1:0]                    core_status_addr
);

  import pr_pkg::*;

  //////////////////////////////
  // Reset registers
  logic rst_r;
  logic core_reset_r;
  logic desc_rst;

  always_ff @(posedge clk) begin
    rst_r        <= rst;
    core_reset_r <= core_reset;
  end

  assign desc_rst = rst_r || core_reset_r;

  //////////////////////////////
  // DMA slices
  dma_wr_t wr_cmd_in;
  dma_wr_t wr_cmd_r;
  logic    wr_valid_r;
  logic    wr_ready_r;
  dma_rd_t rd_cmd_in;
  dma_rd_t rd_cmd_r;
  logic    rd_valid_r;
  logic    rd_ready_r;
  line_t   resp_data_n;
  logic    resp_valid_n;
  logic    resp_ready_n;

  assign wr_cmd_in = '{addr: dma_cmd_wr_addr, data: dma_cmd_wr_data, strb: dma_cmd_wr_strb};
  assign rd_cmd_in = '{addr: dma_cmd_rd_addr};

  pipe_reg #(.data_t(dma_wr_t)) dma_wr_reg (
    .clk(clk), .rst(rst_r),
    .s_data(wr_cmd_in), .s_valid(dma_cmd_wr_en), .s_ready(dma_cmd_wr_ready),
    .m_data(wr_cmd_r), .m_valid(wr_valid_r), .m_ready(wr_ready_r)
  );

  pipe_reg #(.data_t(dma_rd_t)) dma_rd_reg (
    .clk(clk), .rst(rst_r),
    .s_data(rd_cmd_in), .s_valid(dma_cmd_rd_en), .s_ready(dma_cmd_rd_ready),
    .m_data(rd_cmd_r), .m_valid(rd_valid_r), .m_ready(rd_ready_r)
  );

  pipe_reg #(.data_t(line_t)) dma_rd_resp_reg (
    .clk(clk), .rst(rst_r),
    .s_data(resp_data_n), .s_valid(resp_valid_n), .s_ready(resp_ready_n),
    .m_data(dma_rd_resp_data), .m_valid(dma_rd_resp_valid), .m_ready(dma_rd_resp_ready)
  );

  //////////////////////////////
  // Descriptor slices
  desc_t     in_desc_r;
  logic      in_valid_r;
  logic      in_ready_r;
  desc_t     router_desc;
  logic      router_2nd;
  logic      router_valid;
  logic      router_ready;
  desc_out_t out_desc_m;

  pipe_reg #(.data_t(desc_t)) in_desc_reg (
    .clk(clk), .rst(desc_rst),
    .s_data(in_desc), .s_valid(in_desc_valid), .s_ready(in_desc_taken),
    .m_data(in_desc_r), .m_valid(in_valid_r), .m_ready(in_ready_r)
  );

  pipe_reg #(.data_t(desc_out_t)) out_desc_reg (
    .clk(clk), .rst(desc_rst),
    .s_data('{second: router_2nd, desc: router_desc}),
    .s_valid(router_valid), .s_ready(router_ready),
    .m_data(out_desc_m), .m_valid(out_desc_valid), .m_ready(out_desc_ready)
  );

  assign out_desc     = out_desc_m.desc;
  assign out_desc_2nd = out_desc_m.second;

  //////////////////////////////
  // Broadcast channels
  bc_msg_t bc_out_n;
  logic    bc_out_valid_n;
  logic    bc_out_ready_n;
  bc_msg_t bc_in_r;
  logic    bc_in_valid_r;

  pipe_reg #(.data_t(bc_msg_t)) bc_msg_out_reg (
    .clk(clk), .rst(rst_r),
    .s_data(bc_out_n), .s_valid(bc_out_valid_n), .s_ready(bc_out_ready_n),
    .m_data(bc_msg_out), .m_valid(bc_msg_out_valid), .m_ready(bc_msg_out_ready)
  );

  // No back-pressure on the incoming side
  always_ff @(posedge clk) begin
    if (desc_rst) begin
      bc_in_valid_r <= 1'b0;
    end else begin
      bc_in_valid_r <= bc_msg_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    bc_in_r <= bc_msg_in;
  end

  //////////////////////////////
  // Status registers
  logic [31:0] wrapper_status_data_r;
  logic [2:0]  wrapper_status_addr_r;
  logic [31:0] core_status_data_n;
  logic [1:0]  core_status_addr_n;

  always_ff @(posedge clk) begin
    wrapper_status_data_r <= wrapper_status_data;
    wrapper_status_addr_r <= wrapper_status_addr;
    core_status_data      <= core_status_data_n;
    core_status_addr      <= core_status_addr_n;
  end

  //////////////////////////////
  // Core blocks
  logic rx_pulse;
  logic tx_pulse;

  pkt_mem pkt_mem_inst (
    .clk(clk), .rst(rst_r),
    .wr_cmd(wr_cmd_r), .wr_valid(wr_valid_r), .wr_ready(wr_ready_r),
    .rd_cmd(rd_cmd_r), .rd_valid(rd_valid_r), .rd_ready(rd_ready_r),
    .resp_data(resp_data_n), .resp_valid(resp_valid_n), .resp_ready(resp_ready_n),
    .bc_msg(bc_out_n), .bc_valid(bc_out_valid_n), .bc_ready(bc_out_ready_n)
  );

  desc_router desc_router_inst (
    .clk(clk), .rst(rst_r), .core_reset(core_reset_r),
    .in_desc(in_desc_r), .in_valid(in_valid_r), .in_ready(in_ready_r),
    .out_desc(router_desc), .out_2nd(router_2nd),
    .out_valid(router_valid), .out_ready(router_ready),
    .status_data(wrapper_status_data_r), .status_addr(wrapper_status_addr_r),
    .rx_pulse(rx_pulse), .tx_pulse(tx_pulse)
  );

  core_status core_status_inst (
    .clk(clk), .rst(rst_r), .core_reset(core_reset_r),
    .rx_pulse(rx_pulse), .tx_pulse(tx_pulse),
    .bc_msg(bc_in_r), .bc_valid(bc_in_valid_r),
    .status_data(core_status_data_n), .status_addr(core_status_addr_n)
  );

endmodule

`default_nettype wire

// ==== logic/core_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_status (
  input  logic            clk,
  input  logic            rst,
  input  logic            core_reset,

  input  logic            rx_pulse,
  input  logic            tx_pulse,
  input  pr_pkg::bc_msg_t bc_msg,
  input  logic            bc_valid,

  output logic [31:0]     status_data,
  output logic [1:0]      status_addr
);

  import pr_pkg::*;

  logic        clr;
  logic [31:0] rx_count;
  logic [31:0] tx_count;
  logic [31:0] bc_count;
  logic [31:0] bc_last;

  assign clr = rst || core_reset;

  always_ff @(posedge clk) begin
    if (clr) begin
      rx_count <= '0;
      tx_count <= '0;
      bc_count <= '0;
      bc_last  <= '0;
    end else begin
      if (rx_pulse) begin
        rx_count <= rx_count + 32'd1;
      end
      if (tx_pulse) begin
        tx_count <= tx_count + 32'd1;
      end
      if (bc_valid) begin
        bc_count <= bc_count + 32'd1;
        bc_last  <= bc_msg.data;
      end
    end
  end

  // Walks through all four items, one per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      status_addr <= '0;
    end else begin
      status_addr <= status_addr + 2'd1;
    end
  end

  always_comb begin
    case (status_addr)
      STAT_RX_DESC:  status_data = rx_count;
      STAT_TX_DESC:  status_data = tx_count;
      STAT_BC_COUNT: status_data = bc_count;
      STAT_BC_LAST:  status_data = bc_last;
      default:       status_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/desc_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module desc_router (
  input  logic          clk,
  input  logic          rst,
  input  logic          core_reset,

  input  pr_pkg::desc_t in_desc,
  input  logic          in_valid,
  output logic          in_ready,

  output pr_pkg::desc_t out_desc,
  output logic          out_2nd,
  output logic          out_valid,
  input  logic          out_ready,

  input  logic [31:0]   status_data,
  input  logic [2:0]    status_addr,

  output logic          rx_pulse,
  output logic          tx_pulse
);

  import pr_pkg::*;

  logic       clr;
  logic [3:0] port_map [MAP_ENTRIES];
  logic       map_loaded;
  logic       map_load;
  logic [3:0] map_entry;
  logic       drop;
  desc_t      routed;

  assign clr      = rst || core_reset;
  assign map_load = (status_addr == STAT_PORT_MAP);

  assign in_ready = !out_valid || out_ready;
  assign rx_pulse = in_valid && in_ready;
  assign tx_pulse = out_valid && out_ready;

  //////////////////////////////
  // Port map
  // Until a map is loaded descriptors keep their own port
  always_ff @(posedge clk) begin
    if (clr) begin
      map_loaded <= 1'b0;
      for (int i = 0; i < MAP_ENTRIES; i++) begin
        port_map[i] <= '0;
      end
    end else if (map_load) begin
      map_loaded <= 1'b1;
      for (int i = 0; i < MAP_ENTRIES; i++) begin
        port_map[i] <= status_data[i*4 +: 4];
      end
    end
  end

  assign map_entry = port_map[in_desc.port[2:0]];
  assign drop      = map_loaded && (map_entry == PORT_DROP);

  always_comb begin
    routed = in_desc;
    if (map_loaded && !drop) begin
      routed.port = map_entry;
    end
  end

  //////////////////////////////
  // Output register
  always_ff @(posedge clk) begin
    if (clr) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_pulse) begin
      out_desc <= routed;
      out_2nd  <= drop;
    end
  end

endmodule

`default_nettype wire

// ==== logic/pkt_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_mem (
  input  logic            clk,
  input  logic            rst,

  input  pr_pkg::dma_wr_t wr_cmd,
  input  logic            wr_valid,
  output logic            wr_ready,

  input  pr_pkg::dma_rd_t rd_cmd,
  input  logic            rd_valid,
  output logic            rd_ready,

  output pr_pkg::line_t   resp_data,
  output logic            resp_valid,
  input  logic            resp_ready,

  output pr_pkg::bc_msg_t bc_msg,
  output logic            bc_valid,
  input  logic            bc_ready
);

  import pr_pkg::*;

  line_t mem [PMEM_LINES];

  logic                       wr_in_win;
  logic                       wr_is_bc;
  logic                       wr_fire;
  logic [LINE_ADDR_WIDTH-1:0] wr_line;
  logic [1:0]                 wr_lane;
  logic                       rd_in_win;
  logic                       rd_fire;
  logic [LINE_ADDR_WIDTH-1:0] rd_line;

  //////////////////////////////
  // Write side
  assign wr_in_win = (wr_cmd.addr >= PMEM_BASE) && (wr_cmd.addr < PMEM_END);
  assign wr_is_bc  = (wr_cmd.addr >= BC_START_ADDR) && (wr_cmd.addr < PMEM_END);
  assign wr_line   = wr_cmd.addr[LINE_OFFSET +: LINE_ADDR_WIDTH];
  assign wr_lane   = wr_cmd.addr[3:2];

  // Broadcast writes stall until the message register can take them
  assign wr_ready = !wr_is_bc || !bc_valid || bc_ready;
  assign wr_fire  = wr_valid && wr_ready;

  always_ff @(posedge clk) begin
    if (wr_fire && wr_in_win) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (wr_cmd.strb[i]) begin
          mem[wr_line][i*8 +: 8] <= wr_cmd.data[i*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // Read side
  assign rd_in_win = (rd_cmd.addr >= PMEM_BASE) && (rd_cmd.addr < PMEM_END);
  assign rd_line   = rd_cmd.addr[LINE_OFFSET +: LINE_ADDR_WIDTH];
  assign rd_ready  = !resp_valid || resp_ready;
  assign rd_fire   = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else if (rd_fire) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  // Out of window reads return zero
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      resp_data <= rd_in_win ? mem[rd_line] : '0;
    end
  end

  //////////////////////////////
  // Broadcast message
  always_ff @(posedge clk) begin
    if (rst) begin
      bc_valid <= 1'b0;
    end else if (wr_fire && wr_is_bc) begin
      bc_valid <= 1'b1;
    end else if (bc_ready) begin
      bc_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire && wr_is_bc) begin
      bc_msg.data <= wr_cmd.data[wr_lane*32 +: 32];
      bc_msg.strb <= wr_cmd.strb[wr_lane*4 +: 4];
      bc_msg.idx  <= wr_cmd.addr[2 +: BC_IDX_WIDTH];
    end
  end

endmodule

`default_nettype wire

// ==== logic/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type data_t = logic
) (
  input  logic  clk,
  input  logic  rst,

  input  data_t s_data,
  input  logic  s_valid,
  output logic  s_ready,

  output data_t m_data,
  output logic  m_valid,
  input  logic  m_ready
);

  data_t skid_data;
  logic  skid_valid;
  logic  load_main;
  logic  load_skid;
  logic  from_skid;

  // Ready only depends on the skid flop
  assign s_ready = !skid_valid;

  // Main entry takes the input while it is empty or draining
  assign load_main = !skid_valid && (!m_valid || m_ready);

  // Main stalled with a new beat arriving, park it
  assign load_skid = !skid_valid && m_valid && !m_ready && s_valid;

  assign from_skid = skid_valid && m_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (load_main) begin
        m_valid <= s_valid;
      end
      if (load_skid) begin
        skid_valid <= 1'b1;
      end else if (from_skid) begin
        skid_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_main) begin
      m_data <= s_data;
    end else if (from_skid) begin
      m_data <= skid_data;
    end
    if (load_skid) begin
      skid_data <= s_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/pr_pkg.sv ====
`default_nettype none

package pr_pkg;

  //////////////////////////////
  // Widths
  localparam int DATA_WIDTH  = 128;
  localparam int STRB_WIDTH  = DATA_WIDTH / 8;
  localparam int ADDR_WIDTH  = 26;
  localparam int LINE_OFFSET = $clog2(STRB_WIDTH);

  //////////////////////////////
  // Memory map
  localparam int PMEM_LINES      = 4096;
  localparam int PMEM_SIZE       = PMEM_LINES * STRB_WIDTH;
  localparam int LINE_ADDR_WIDTH = $clog2(PMEM_LINES);

  localparam logic [ADDR_WIDTH-1:0] PMEM_BASE = ADDR_WIDTH'(32'h0100_0000);
  localparam logic [ADDR_WIDTH-1:0] PMEM_END  = PMEM_BASE + ADDR_WIDTH'(PMEM_SIZE);

  // Broadcast region sits at the top of the packet memory
  localparam int BC_REGION_SIZE = 8192;
  localparam logic [ADDR_WIDTH-1:0] BC_START_ADDR = PMEM_END - ADDR_WIDTH'(BC_REGION_SIZE);
  localparam int BC_IDX_WIDTH   = $clog2(BC_REGION_SIZE) - 2;
  localparam int MSG_WIDTH      = 32 + 4 + BC_IDX_WIDTH;

  //////////////////////////////
  // Descriptors and status
  localparam int DESC_WIDTH  = 64;
  localparam int MAP_ENTRIES = 8;
  localparam logic [3:0] PORT_DROP = 4'hF;

  localparam logic [2:0] STAT_PORT_MAP = 3'd1;

  localparam logic [1:0] STAT_RX_DESC  = 2'd0;
  localparam logic [1:0] STAT_TX_DESC  = 2'd1;
  localparam logic [1:0] STAT_BC_COUNT = 2'd2;
  localparam logic [1:0] STAT_BC_LAST  = 2'd3;

  //////////////////////////////
  // Payload types
  typedef logic [DATA_WIDTH-1:0] line_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    line_t                 data;
    logic [STRB_WIDTH-1:0] strb;
  } dma_wr_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
  } dma_rd_t;

  // Tag occupies bits 63:28
  typedef struct packed {
    logic [DESC_WIDTH-29:0] tag;
    logic [3:0]             port;
    logic [7:0]             slot;
    logic [15:0]            len;
  } desc_t;

  typedef struct packed {
    logic  second;
    desc_t desc;
  } desc_out_t;

  typedef struct packed {
    logic [31:0]             data;
    logic [3:0]              strb;
    logic [BC_IDX_WIDTH-1:0] idx;
  } bc_msg_t;

endpackage

`default_nettype wire
